/* verilog/vtb_pkg.sv */
`default_nettype none

package vtb_pkg;

	// Pixel bus shape
	localparam int ppc   = 2;                       // Pixels per clock
	localparam int bpc   = 8;                       // Bits per component
	localparam int pix_w = ppc * bpc;               // One component, all pixels

	// Colour levels
	localparam logic [bpc-1:0] lvl_hi = 8'd180;
	localparam logic [bpc-1:0] lvl_lo = 8'd16;

	// Register map
	localparam logic [7:0] addr_ctrl = 8'h00;       // [0] run, [3:1] format
	localparam logic [7:0] addr_hact = 8'h04;       // Active pixels
	localparam logic [7:0] addr_hblk = 8'h08;       // Blank pixels
	localparam logic [7:0] addr_vact = 8'h0C;       // Active lines
	localparam logic [7:0] addr_vblk = 8'h10;       // Blank lines

	// Small frame out of reset
	localparam logic [15:0] hact_rst = 16'd64;
	localparam logic [15:0] hblk_rst = 16'd16;
	localparam logic [15:0] vact_rst = 16'd16;
	localparam logic [15:0] vblk_rst = 16'd2;

	typedef enum logic [2:0]
	{
		fmt_full  = 3'd0,                           // Bars, ramp band, line band
		fmt_red   = 3'd1,
		fmt_green = 3'd2,
		fmt_blue  = 3'd3,
		fmt_ramp  = 3'd4
	} tpg_fmt_e;

	typedef struct packed
	{
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed
	{
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Control and geometry, 68 bits
	typedef struct packed
	{
		logic        run;
		tpg_fmt_e    fmt;
		logic [15:0] hact;
		logic [15:0] hblk;
		logic [15:0] vact;
		logic [15:0] vblk;
	} tpg_cfg_t;

	typedef struct packed
	{
		logic vs;
		logic hs;
		logic de;
	} vid_sync_t;

	typedef struct packed
	{
		logic [pix_w-1:0] r;
		logic [pix_w-1:0] g;
		logic [pix_w-1:0] b;
	} vid_pix_t;

endpackage

`default_nettype wire

/* verilog/vtb_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vtb_apb_regs
(
	input wire                 CLK_IN,
	input wire                 rst_n,
	input wire vtb_pkg::apb_req_t apb_req,     // From bus master
	output vtb_pkg::apb_rsp_t  apb_rsp,
	output vtb_pkg::tpg_cfg_t  cfg             // To timing and pattern blocks
);

logic        access;                            // Access phase
logic        wr_en;
logic        hit;                               // Mapped address
logic [31:0] rdata;

	assign access = apb_req.psel & apb_req.penable;
	assign wr_en  = access & apb_req.pwrite;

// Address decode and read-back
	always_comb
	begin
		hit   = 1'b1;
		rdata = '0;                                 // Unused bits read zero
		case (apb_req.paddr)
			vtb_pkg::addr_ctrl : rdata[3:0]  = {cfg.fmt, cfg.run};
			vtb_pkg::addr_hact : rdata[15:0] = cfg.hact;
			vtb_pkg::addr_hblk : rdata[15:0] = cfg.hblk;
			vtb_pkg::addr_vact : rdata[15:0] = cfg.vact;
			vtb_pkg::addr_vblk : rdata[15:0] = cfg.vblk;
			default            : hit = 1'b0;    // Unmapped
		endcase
	end

// Response, zero wait states
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access & ~hit;
	assign apb_rsp.prdata  = (access & hit) ? rdata : '0;

// Registers
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg.run  <= 1'b0;                       // Stopped
			cfg.fmt  <= vtb_pkg::fmt_full;
			cfg.hact <= vtb_pkg::hact_rst;
			cfg.hblk <= vtb_pkg::hblk_rst;
			cfg.vact <= vtb_pkg::vact_rst;
			cfg.vblk <= vtb_pkg::vblk_rst;
		end

		// Write on the edge closing the access phase
		else if (wr_en && hit)
		begin
			case (apb_req.paddr)
				vtb_pkg::addr_ctrl :
				begin
					cfg.run <= apb_req.pwdata[0];
					cfg.fmt <= vtb_pkg::tpg_fmt_e'(apb_req.pwdata[3:1]);
				end
				vtb_pkg::addr_hact : cfg.hact <= apb_req.pwdata[15:0];
				vtb_pkg::addr_hblk : cfg.hblk <= apb_req.pwdata[15:0];
				vtb_pkg::addr_vact : cfg.vact <= apb_req.pwdata[15:0];
				vtb_pkg::addr_vblk : cfg.vblk <= apb_req.pwdata[15:0];
				default : ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/vtb_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vtb_timing_gen
(
	input wire                  CLK_IN,
	input wire                  rst_n,
	input wire vtb_pkg::tpg_cfg_t cfg,
	output vtb_pkg::vid_sync_t  sync            // Registered vs, hs, de
);

logic        running;                           // Left idle
logic [15:0] hcnt;                              // Clock in line
logic [15:0] vcnt;                              // Line in frame
logic [15:0] h_act;                             // Latched geometry, in clocks
logic [15:0] h_blk;
logic [15:0] v_act;                             // Latched geometry, in lines
logic [15:0] v_blk;
logic [15:0] h_tot;
logic [15:0] v_tot;
logic        h_end;
logic        v_end;
logic [15:0] nxt_h;
logic [15:0] nxt_v;

	assign h_tot = h_act + h_blk;
	assign v_tot = v_act + v_blk;
	assign h_end = (hcnt == h_tot - 16'd1);     // Last clock of line
	assign v_end = (vcnt == v_tot - 16'd1);     // Last line of frame

// Next position
	always_comb
	begin
		nxt_h = '0;                                 // Idle exit starts at 0,0
		nxt_v = '0;
		if (running)
		begin
			if (h_end)
				nxt_v = v_end ? 16'd0 : vcnt + 16'd1;
			else
			begin
				nxt_h = hcnt + 16'd1;
				nxt_v = vcnt;
			end
		end
	end

// Geometry, tracked in idle and reloaded per frame
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_act <= '0;
			h_blk <= '0;
			v_act <= '0;
			v_blk <= '0;
		end
		else if (!running || (h_end && v_end))
		begin
			h_act <= {1'b0, cfg.hact[15:1]};        // Two pixels per clock
			h_blk <= {1'b0, cfg.hblk[15:1]};
			v_act <= cfg.vact;
			v_blk <= cfg.vblk;
		end
	end

// Counters and syncs
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			hcnt    <= '0;
			vcnt    <= '0;
			sync    <= '0;
		end

		// Idle, all syncs low
		else if (!cfg.run)
		begin
			running <= 1'b0;
			hcnt    <= '0;
			vcnt    <= '0;
			sync    <= '0;
		end

		else
		begin
			running <= 1'b1;
			hcnt    <= nxt_h;
			vcnt    <= nxt_v;
			sync.de <= (nxt_v < v_act) && (nxt_h < h_act);
			sync.hs <= (nxt_h >= h_act) && (nxt_h < h_act + 16'd2);  // 2 clocks into blank
			sync.vs <= (nxt_v == v_act);            // First blank line
		end
	end

endmodule

`default_nettype wire

/* verilog/vtb_tpg.sv */
`timescale 1ns/1ps
`default_nettype none

module vtb_tpg
(
	input wire                  CLK_IN,
	input wire                  rst_n,
	input wire vtb_pkg::tpg_cfg_t cfg,
	input wire vtb_pkg::vid_sync_t sync_in,     // From timing generator
	output vtb_pkg::vid_sync_t  sync_out,       // Delayed by two
	output vtb_pkg::vid_pix_t   pix
);

vtb_pkg::vid_sync_t s1;                         // Sync stage 1
vtb_pkg::vid_sync_t s2;                         // Sync stage 2, also edge flop
logic               vs_re;
logic               de_fe;
logic [15:0]        pcnt;                       // Clock in active line
logic [15:0]        lcnt;                       // Line in frame
logic [15:0]        bar_w;                      // Bar width in clocks
logic [15:0]        vquad;
logic [15:0]        ramp_str;                   // First ramp line
logic [15:0]        lines_str;                  // First line-band line
logic [2:0]         bar_rgb;                    // Bar colour as r,g,b high flags
vtb_pkg::vid_pix_t  ramp_pix;
vtb_pkg::vid_pix_t  lines_pix;
vtb_pkg::vid_pix_t  nxt_pix;

	// Flat colour, each flag selects high or low level
	function automatic vtb_pkg::vid_pix_t solid(input logic [2:0] rgb);
		vtb_pkg::vid_pix_t p;
		p.r = {vtb_pkg::ppc{rgb[2] ? vtb_pkg::lvl_hi : vtb_pkg::lvl_lo}};
		p.g = {vtb_pkg::ppc{rgb[1] ? vtb_pkg::lvl_hi : vtb_pkg::lvl_lo}};
		p.b = {vtb_pkg::ppc{rgb[0] ? vtb_pkg::lvl_hi : vtb_pkg::lvl_lo}};
		return p;
	endfunction

// Sync delay
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1 <= '0;
			s2 <= '0;
		end
		else
		begin
			s1 <= sync_in;
			s2 <= s1;
		end
	end

	assign sync_out = s2;

	// Edges of stage 1 against stage 2
	assign vs_re = s1.vs & ~s2.vs;
	assign de_fe = s2.de & ~s1.de;

// Pixel and line counters
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pcnt <= '0;
			lcnt <= '0;
		end
		else if (!cfg.run)
		begin
			pcnt <= '0;                             // Held while stopped
			lcnt <= '0;
		end
		else
		begin
			pcnt <= s1.de ? pcnt + 16'd1 : 16'd0;
			if (vs_re)
				lcnt <= '0;                         // New frame
			else if (de_fe)
				lcnt <= lcnt + 16'd1;               // End of active line
		end
	end

// Band limits from the active height
	assign vquad     = {2'b00, cfg.vact[15:2]};
	assign ramp_str  = {vquad[14:0], 1'b0};
	assign lines_str = vquad + {vquad[14:0], 1'b0};
	assign bar_w     = {4'b0000, cfg.hact[15:4]};   // hact/16 clocks

// Bar select
	always_comb
	begin
		if (pcnt < bar_w)
			bar_rgb = 3'b111;                       // White
		else if (pcnt < bar_w * 16'd2)
			bar_rgb = 3'b110;                       // Yellow
		else if (pcnt < bar_w * 16'd3)
			bar_rgb = 3'b011;                       // Cyan
		else if (pcnt < bar_w * 16'd4)
			bar_rgb = 3'b010;                       // Green
		else if (pcnt < bar_w * 16'd5)
			bar_rgb = 3'b101;                       // Magenta
		else if (pcnt < bar_w * 16'd6)
			bar_rgb = 3'b100;                       // Red
		else if (pcnt < bar_w * 16'd7)
			bar_rgb = 3'b001;                       // Blue
		else
			bar_rgb = 3'b000;                       // Black
	end

	// Ramp, upper pixel odd, lower pixel even
	assign ramp_pix.r  = {pcnt[6:0], 1'b1, pcnt[6:0], 1'b0};
	assign ramp_pix.g  = ramp_pix.r;
	assign ramp_pix.b  = ramp_pix.r;

	// Line band, full scale on odd clocks
	assign lines_pix.r = {vtb_pkg::pix_w{pcnt[0]}};
	assign lines_pix.g = lines_pix.r;
	assign lines_pix.b = lines_pix.r;

// Format mux
	always_comb
	begin
		case (cfg.fmt)
			vtb_pkg::fmt_red   : nxt_pix = solid(3'b100);
			vtb_pkg::fmt_green : nxt_pix = solid(3'b010);
			vtb_pkg::fmt_blue  : nxt_pix = solid(3'b001);
			vtb_pkg::fmt_ramp  : nxt_pix = ramp_pix;
			default :
			begin
				if (lcnt >= lines_str)
					nxt_pix = lines_pix;            // Bottom quarter
				else if (lcnt >= ramp_str)
					nxt_pix = ramp_pix;             // Third quarter
				else
					nxt_pix = solid(bar_rgb);       // Top half
			end
		endcase
	end

	// Lines up with stage 2 de
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
			pix <= '0;
		else
			pix <= nxt_pix;
	end

endmodule

`default_nettype wire

/* verilog/vtb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vtb_top
(
	input wire                  CLK_IN,
	input wire                  rst_n,
	input wire vtb_pkg::apb_req_t apb_req,
	output vtb_pkg::apb_rsp_t   apb_rsp,
	output vtb_pkg::vid_sync_t  vid_sync,
	output vtb_pkg::vid_pix_t   vid_pix
);

vtb_pkg::tpg_cfg_t  cfg;                        // Shared configuration
vtb_pkg::vid_sync_t tg_sync;                    // Timing generator syncs

	vtb_apb_regs u_regs
	(
		.CLK_IN  (CLK_IN),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.cfg     (cfg)
	);

	vtb_timing_gen u_timing
	(
		.CLK_IN (CLK_IN),
		.rst_n  (rst_n),
		.cfg    (cfg),
		.sync   (tg_sync)
	);

	// Pattern and delayed syncs out
	vtb_tpg u_tpg
	(
		.CLK_IN   (CLK_IN),
		.rst_n    (rst_n),
		.cfg      (cfg),
		.sync_in  (tg_sync),
		.sync_out (vid_sync),
		.pix      (vid_pix)
	);

endmodule

`default_nettype wire

/* bench/vtb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module vtb_checker
(
	input wire                     CLK_IN,
	input wire                     rst_n,
	input wire vtb_pkg::apb_req_t  apb_req,
	input wire vtb_pkg::apb_rsp_t  apb_rsp,
	input wire vtb_pkg::vid_sync_t vid_sync,
	input wire vtb_pkg::vid_pix_t  vid_pix
);

int                fail_cnt = 0;                // Assertion failures so far
logic              access;                      // APB access phase
logic              mapped;
logic              run;                         // Config seen on the bus
logic [2:0]        fmt;
logic [15:0]       hact;
logic [15:0]       hblk;
logic [15:0]       vact;
logic [15:0]       line_clks;                   // Clocks per line
logic [3:0]        run_hist;                    // Run over the last four clocks
logic [15:0]       col_q;                       // Clock within active line
logic [15:0]       line_q;                      // Active lines done in frame
logic [15:0]       gap_q;                       // Clocks since hs rose
logic [15:0]       vs_len;
logic              de_q;
logic              hs_q;
logic              hs_q2;
logic              vs_q;
logic              hs_seen;                     // Period known after first hs
vtb_pkg::vid_pix_t exp_pix;

	// Bar number to r,g,b high flags
	function automatic logic [2:0] bar_flags(input logic [15:0] idx);
		case (idx)
			16'd0   : return 3'b111;                // White
			16'd1   : return 3'b110;                // Yellow
			16'd2   : return 3'b011;                // Cyan
			16'd3   : return 3'b010;                // Green
			16'd4   : return 3'b101;                // Magenta
			16'd5   : return 3'b100;                // Red
			16'd6   : return 3'b001;                // Blue
			default : return 3'b000;
		endcase
	endfunction

	// Expected pixel at column c of active line l
	function automatic vtb_pkg::vid_pix_t pattern(input logic [15:0] c, input logic [15:0] l);
		logic [15:0]       q;
		logic [15:0]       bw;
		logic [15:0]       ramp;
		logic [2:0]        rgb;
		vtb_pkg::vid_pix_t p;
		q    = vact / 16'd4;
		bw   = hact / 16'd16;
		ramp = {c[6:0], 1'b1, c[6:0], 1'b0};    // Upper pixel odd
		case (fmt)
			vtb_pkg::fmt_red   : rgb = 3'b100;
			vtb_pkg::fmt_green : rgb = 3'b010;
			vtb_pkg::fmt_blue  : rgb = 3'b001;
			vtb_pkg::fmt_ramp  : return {ramp, ramp, ramp};
			default :
			begin
				if (l >= q * 16'd3)
					return {3{{16{c[0]}}}};         // Line band
				if (l >= q * 16'd2)
					return {ramp, ramp, ramp};
				rgb = bar_flags((bw == 16'd0) ? 16'd7 : c / bw);
			end
		endcase
		p.r = {vtb_pkg::ppc{rgb[2] ? vtb_pkg::lvl_hi : vtb_pkg::lvl_lo}};
		p.g = {vtb_pkg::ppc{rgb[1] ? vtb_pkg::lvl_hi : vtb_pkg::lvl_lo}};
		p.b = {vtb_pkg::ppc{rgb[0] ? vtb_pkg::lvl_hi : vtb_pkg::lvl_lo}};
		return p;
	endfunction

	assign access    = apb_req.psel & apb_req.penable;
	assign mapped    = apb_req.paddr inside {vtb_pkg::addr_ctrl, vtb_pkg::addr_hact,
		vtb_pkg::addr_hblk, vtb_pkg::addr_vact, vtb_pkg::addr_vblk};
	assign line_clks = {1'b0, hact[15:1]} + {1'b0, hblk[15:1]};

	// Follows the format and geometry as well as the position
	always_comb
		exp_pix = pattern(col_q, line_q);

// Own copy of the configuration from bus writes
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run  <= 1'b0;
			fmt  <= 3'd0;
			hact <= vtb_pkg::hact_rst;
			hblk <= vtb_pkg::hblk_rst;
			vact <= vtb_pkg::vact_rst;
		end
		else if (access && apb_req.pwrite)
		begin
			case (apb_req.paddr)
				vtb_pkg::addr_ctrl :
				begin
					run <= apb_req.pwdata[0];
					fmt <= apb_req.pwdata[3:1];
				end
				vtb_pkg::addr_hact : hact <= apb_req.pwdata[15:0];
				vtb_pkg::addr_hblk : hblk <= apb_req.pwdata[15:0];
				vtb_pkg::addr_vact : vact <= apb_req.pwdata[15:0];
				default : ;
			endcase
		end
	end

// Position in the output stream
	always_ff @(posedge CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run_hist <= '0;
			col_q    <= '0;
			line_q   <= '0;
			gap_q    <= '0;
			vs_len   <= '0;
			de_q     <= 1'b0;
			hs_q     <= 1'b0;
			hs_q2    <= 1'b0;
			vs_q     <= 1'b0;
			hs_seen  <= 1'b0;
		end
		else
		begin
			run_hist <= {run_hist[2:0], run};
			de_q     <= vid_sync.de;
			hs_q     <= vid_sync.hs;
			hs_q2    <= hs_q;
			vs_q     <= vid_sync.vs;
			col_q    <= vid_sync.de ? col_q + 16'd1 : 16'd0;
			vs_len   <= vid_sync.vs ? vs_len + 16'd1 : 16'd0;
			gap_q    <= (vid_sync.hs && !hs_q) ? 16'd1 : gap_q + 16'd1;
			if (vid_sync.vs || run_hist == 4'd0)
				line_q <= '0;                       // New frame or stopped
			else if (!vid_sync.de && col_q != 16'd0)
				line_q <= line_q + 16'd1;           // Active line just ended
			if (run_hist == 4'd0)
				hs_seen <= 1'b0;
			else if (vid_sync.hs && !hs_q)
				hs_seen <= 1'b1;
		end
	end

	a_pready : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		access |-> apb_rsp.pready)
		else
		begin
			$error("pready low during an access phase");
			fail_cnt++;
		end

	// Unmapped address gives an error and zero data
	a_slverr : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		access |-> (apb_rsp.pslverr == !mapped) && (mapped || apb_rsp.prdata == 32'd0))
		else
		begin
			$error("Wrong error response or read data for an unmapped address");
			fail_cnt++;
		end

	a_idle : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		run_hist == 4'd0 |-> vid_sync == '0)
		else
		begin
			$error("Sync outputs active while stopped");
			fail_cnt++;
		end

	a_hact : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		!vid_sync.de && col_q != 16'd0 |-> col_q == {1'b0, hact[15:1]})
		else
		begin
			$error("Fail active clocks expected %0d actual %0d",
				$sampled(hact) / 2, $sampled(col_q));
			fail_cnt++;
		end

	a_vact : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		vid_sync.vs && !vs_q |-> line_q == vact)
		else
		begin
			$error("Fail active lines expected %0d actual %0d",
				$sampled(vact), $sampled(line_q));
			fail_cnt++;
		end

	a_vs_len : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		!vid_sync.vs && vs_q |-> vs_len == line_clks)
		else
		begin
			$error("Fail vsync clocks expected %0d actual %0d",
				$sampled(line_clks), $sampled(vs_len));
			fail_cnt++;
		end

	a_blank : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		vid_sync.vs || vid_sync.hs |-> !vid_sync.de)
		else
		begin
			$error("Data enable high during a sync pulse");
			fail_cnt++;
		end

	a_hs_pos : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		de_q && !vid_sync.de |-> vid_sync.hs)
		else
		begin
			$error("hsync did not start right after active data");
			fail_cnt++;
		end

	// Two clocks wide
	a_hs_len : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		hs_q |-> vid_sync.hs == !hs_q2)
		else
		begin
			$error("hsync pulse is not two clocks wide");
			fail_cnt++;
		end

	a_hs_per : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		vid_sync.hs && !hs_q && hs_seen |-> gap_q == line_clks)
		else
		begin
			$error("Fail hsync period expected %0d actual %0d",
				$sampled(line_clks), $sampled(gap_q));
			fail_cnt++;
		end

	a_pixel : assert property (@(posedge CLK_IN) disable iff (!rst_n)
		vid_sync.de |-> vid_pix == exp_pix)
		else
		begin
			$error("Fail pixel expected %h actual %h", $sampled(exp_pix), $sampled(vid_pix));
			fail_cnt++;
		end

endmodule

bind vtb_top vtb_checker u_chk
(
	.CLK_IN   (CLK_IN),
	.rst_n    (rst_n),
	.apb_req  (apb_req),
	.apb_rsp  (apb_rsp),
	.vid_sync (vid_sync),
	.vid_pix  (vid_pix)
);

`default_nettype wire

/* bench/vtb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vtb_tb;

localparam int line_clks = (int'(vtb_pkg::hact_rst) + int'(vtb_pkg::hblk_rst)) / 2;
localparam int frame_clks = line_clks * (int'(vtb_pkg::vact_rst) + int'(vtb_pkg::vblk_rst));
localparam int wd_ns = 12 * frame_clks * 8;     // Twelve frames at 8 ns

logic               CLK_IN;
logic               rst_n;
vtb_pkg::apb_req_t  apb_req;
vtb_pkg::apb_rsp_t  apb_rsp;
vtb_pkg::vid_sync_t vid_sync;
vtb_pkg::vid_pix_t  vid_pix;
int                 rd_errs;                    // Read-back mismatches
int                 f0;                         // First format of the rotation
logic [31:0]        seed;
logic [31:0]        wdata;
logic [31:0]        rdata;
logic               err;
logic [2:0]         fmt;
logic [7:0]         reg_addr [5] = '{vtb_pkg::addr_ctrl, vtb_pkg::addr_hact,
	vtb_pkg::addr_hblk, vtb_pkg::addr_vact, vtb_pkg::addr_vblk};
logic [31:0]        reg_mask [5] = '{32'h0000_000F, 32'h0000_FFFF, 32'h0000_FFFF,
	32'h0000_FFFF, 32'h0000_FFFF};
string              reg_name [5] = '{"ctrl", "hact", "hblk", "vact", "vblk"};

	vtb_top u_vtb_top
	(
		.CLK_IN   (CLK_IN),
		.rst_n    (rst_n),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.vid_sync (vid_sync),
		.vid_pix  (vid_pix)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge CLK_IN);
		apb_req.psel    = 1'b1;                     // Setup
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(negedge CLK_IN);
		apb_req.penable = 1'b1;                     // Access
		@(negedge CLK_IN);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic slverr);
		@(negedge CLK_IN);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		@(negedge CLK_IN);
		apb_req.penable = 1'b1;
		@(negedge CLK_IN);
		data            = apb_rsp.prdata;           // Bus still held, response stable
		slverr          = apb_rsp.pslverr;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			rd_errs++;
		end
	endtask

	task automatic wait_vs(input logic level);
		@(negedge CLK_IN);
		while (vid_sync.vs !== level)
			@(negedge CLK_IN);
	endtask

	// Run whole frames, then stop inside the second blanking line
	task automatic run_frames(input logic [2:0] f, input int frames);
		apb_write(vtb_pkg::addr_ctrl, {28'd0, f, 1'b1});
		repeat (frames)
		begin
			wait_vs(1'b1);
			wait_vs(1'b0);
		end
		apb_write(vtb_pkg::addr_ctrl, {28'd0, f, 1'b0});
		repeat (8) @(negedge CLK_IN);               // Pipeline drains to idle
	endtask

	initial
	begin
		CLK_IN = 1'b0;
		forever #4 CLK_IN = ~CLK_IN;
	end

	initial
	begin
		#(wd_ns);
		$display("Timeout after %0d ns, the test sequence did not finish", wd_ns);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		apb_req = '0;
		rst_n   = 1'b0;
		rd_errs = 0;
		seed    = 32'h2a36;
		repeat (3) @(negedge CLK_IN);
		rst_n = 1'b1;
		repeat (6) @(negedge CLK_IN);               // Idle after reset

		// Register read-back, masked to each width
		for (int i = 0; i < 5; i++)
		begin
			seed  = lcg_next(seed);
			wdata = (i == 0) ? (seed & 32'hFFFF_FFFE) : seed;  // Run stays low
			apb_write(reg_addr[i], wdata);
			apb_read(reg_addr[i], rdata, err);
			check_val(reg_name[i], wdata & reg_mask[i], rdata);
			check_val("pslverr", 32'd0, {31'd0, err});
		end
		seed = lcg_next(seed);
		apb_write(8'h14, seed);                     // Unmapped
		apb_read(8'h14, rdata, err);
		check_val("unmapped read", 32'd0, rdata);
		check_val("unmapped pslverr", 32'd1, {31'd0, err});

		// Back to the small frame
		apb_write(vtb_pkg::addr_ctrl, 32'd0);
		apb_write(vtb_pkg::addr_hact, {16'd0, vtb_pkg::hact_rst});
		apb_write(vtb_pkg::addr_hblk, {16'd0, vtb_pkg::hblk_rst});
		apb_write(vtb_pkg::addr_vact, {16'd0, vtb_pkg::vact_rst});
		apb_write(vtb_pkg::addr_vblk, {16'd0, vtb_pkg::vblk_rst});

		// Every format once, in an order that starts at a random one
		seed = lcg_next(seed);
		f0   = int'(seed[15:8]) % 5;
		for (int i = 0; i < 5; i++)
		begin
			fmt = 3'((f0 + i) % 5);
			run_frames(fmt, (fmt == vtb_pkg::fmt_full) ? 2 : 1);
		end

		// New geometry while stopped
		apb_write(vtb_pkg::addr_hact, 32'd96);
		apb_write(vtb_pkg::addr_vact, 32'd12);
		run_frames(vtb_pkg::fmt_full, 2);

		$display("Errors: read-back %0d, assertions %0d", rd_errs, u_vtb_top.u_chk.fail_cnt);
		if (rd_errs == 0 && u_vtb_top.u_chk.fail_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/vtb_pkg.sv
verilog/vtb_apb_regs.sv
verilog/vtb_timing_gen.sv
verilog/vtb_tpg.sv
verilog/vtb_top.sv
bench/vtb_checker.sv
bench/vtb_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the video test-pattern testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vtb_tb -f verilog.f \
	--Mdir obj_dir -o vtb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/vtb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
